// File: hdl/dcache_defines.svh
// data cache geometry and widths
// two-way set-associative, one 64-bit word per line
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

`define DC_ADDR_W   32
`define DC_DATA_W   64
`define DC_MASK_W   8

// index is address bits 8..3, tag is bits 31..9
`define DC_SETS     64
`define DC_INDEX_W  6
`define DC_OFFSET_W 3
`define DC_TAG_W    23

`define DC_WAYS     2

`endif

// File: hdl/dcache_pkg.sv
// data cache package
// shared field types and the controller state encoding
`include "dcache_defines.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]  addr_t;
    typedef logic [`DC_DATA_W-1:0]  data_t;
    typedef logic [`DC_MASK_W-1:0]  mask_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_TAG_W-1:0]   tag_t;
    typedef logic                   way_t;

    // one-hot access controller states
    typedef enum logic [5:0] {
        IDLE   = 6'b000001,
        LOOKUP = 6'b000010,
        HIT    = 6'b000100,
        WBCK   = 6'b001000,
        FILL   = 6'b010000,
        DONE   = 6'b100000
    } ctrl_state_e;

endpackage

// File: hdl/dcache_array.sv
// data cache storage array
// single port, whole-entry write, read data registered one cycle
// after the index; serves both the tag and the data ways
`include "dcache_defines.svh"

module dcache_array #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = `DC_SETS
) (
    input  logic              clk,
    input  logic              we_i,
    input  dcache_pkg::index_t index_i,
    input  entry_t            wdata_i,
    output entry_t            rdata_o
);

    entry_t mem [DEPTH];

    // read returns the old entry when written on the same edge
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[index_i] <= wdata_i;
        end
        rdata_o <= mem[index_i];
    end

endmodule

// File: hdl/dcache_meta.sv
// data cache metadata store
// valid, dirty and LRU state per set, tag compare across both ways
// and victim choice for a miss
`include "dcache_defines.svh"

module dcache_meta (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::index_t index_i,
    input  dcache_pkg::tag_t   tag_i,
    input  dcache_pkg::tag_t   tag0_i,
    input  dcache_pkg::tag_t   tag1_i,
    input  logic               touch_i,
    input  dcache_pkg::way_t   touch_way_i,
    input  logic               fill_i,
    input  logic               set_dirty_i,
    output logic               hit_o,
    output dcache_pkg::way_t   hit_way_o,
    output dcache_pkg::way_t   victim_way_o,
    output logic               victim_dirty_o
);
    import dcache_pkg::*;

    logic [`DC_WAYS-1:0] valid_q [`DC_SETS];
    logic [`DC_WAYS-1:0] dirty_q [`DC_SETS];
    // way to replace next in each set
    logic [`DC_SETS-1:0] lru_q;

    logic [`DC_WAYS-1:0] valid_set;
    logic [`DC_WAYS-1:0] dirty_set;
    logic [`DC_WAYS-1:0] match;

    assign valid_set = valid_q[index_i];
    assign dirty_set = dirty_q[index_i];

    assign match[0] = valid_set[0] && (tag0_i == tag_i);
    assign match[1] = valid_set[1] && (tag1_i == tag_i);

    assign hit_o     = |match;
    assign hit_way_o = way_t'(match[1]);

    // empty way first, way 0 before way 1
    always_comb begin
        if (!valid_set[0]) begin
            victim_way_o = 1'b0;
        end else if (!valid_set[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_q[index_i];
        end
    end

    assign victim_dirty_o = valid_set[victim_way_o] && dirty_set[victim_way_o];

    // fill and set_dirty act on the way given by touch_way_i
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `DC_SETS; i++) begin
                valid_q[i] <= '0;
                dirty_q[i] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (touch_i) begin
                lru_q[index_i] <= ~touch_way_i;
            end
            if (fill_i) begin
                valid_q[index_i][touch_way_i] <= 1'b1;
                dirty_q[index_i][touch_way_i] <= 1'b0;
            end
            if (set_dirty_i) begin
                dirty_q[index_i][touch_way_i] <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/dcache_ctrl.sv
// data cache access controller
// one access at a time: lookup, hit merge, dirty writeback and
// line fill, with four-phase handshakes on the CPU and memory sides
`include "dcache_defines.svh"

module dcache_ctrl (
    input  logic                clk,
    input  logic                rst,
    // cpu side
    input  logic                cpu_req_i,
    input  logic                cpu_we_i,
    input  dcache_pkg::addr_t   cpu_addr_i,
    input  dcache_pkg::data_t   cpu_wdata_i,
    input  dcache_pkg::mask_t   cpu_mask_i,
    output logic                cpu_ack_o,
    output dcache_pkg::data_t   cpu_rdata_o,
    // memory side
    output logic                mem_req_o,
    output logic                mem_we_o,
    output dcache_pkg::addr_t   mem_addr_o,
    output dcache_pkg::data_t   mem_wdata_o,
    input  logic                mem_ack_i,
    input  dcache_pkg::data_t   mem_rdata_i,
    // array writes
    output logic [`DC_WAYS-1:0] tag_we_o,
    output logic [`DC_WAYS-1:0] data_we_o,
    output dcache_pkg::tag_t    tag_wdata_o,
    output dcache_pkg::data_t   data_wdata_o,
    // array reads
    input  dcache_pkg::data_t   data0_i,
    input  dcache_pkg::data_t   data1_i,
    input  dcache_pkg::tag_t    tag0_i,
    input  dcache_pkg::tag_t    tag1_i,
    // metadata
    input  logic                hit_i,
    input  dcache_pkg::way_t    hit_way_i,
    input  dcache_pkg::way_t    victim_way_i,
    input  logic                victim_dirty_i,
    output logic                touch_o,
    output dcache_pkg::way_t    touch_way_o,
    output logic                fill_o,
    output logic                set_dirty_o
);
    import dcache_pkg::*;

    ctrl_state_e state_q;
    way_t        victim_q;

    index_t cpu_index;
    tag_t   cpu_tag;
    tag_t   victim_tag;
    data_t  victim_word;
    data_t  hit_word;
    data_t  merged_word;
    addr_t  wb_addr;
    addr_t  fill_addr;
    logic   fill_write;
    logic   store_hit;
    logic   wbck_done;

    assign cpu_index = cpu_addr_i[`DC_INDEX_W+`DC_OFFSET_W-1:`DC_OFFSET_W];
    assign cpu_tag   = cpu_addr_i[`DC_ADDR_W-1:`DC_INDEX_W+`DC_OFFSET_W];

    assign victim_tag  = victim_way_i ? tag1_i : tag0_i;
    assign victim_word = victim_way_i ? data1_i : data0_i;
    assign hit_word    = hit_way_i ? data1_i : data0_i;

    // word-aligned memory addresses
    assign wb_addr   = {victim_tag, cpu_index, {`DC_OFFSET_W{1'b0}}};
    assign fill_addr = {cpu_tag, cpu_index, {`DC_OFFSET_W{1'b0}}};

    // byte merge of store data into the stored word
    always_comb begin
        for (int b = 0; b < `DC_MASK_W; b++) begin
            merged_word[b*8 +: 8] = cpu_mask_i[b] ? cpu_wdata_i[b*8 +: 8]
                                                  : hit_word[b*8 +: 8];
        end
    end

    assign fill_write = (state_q == FILL) && mem_req_o && mem_ack_i;
    assign store_hit  = (state_q == HIT) && cpu_we_i;
    assign wbck_done  = (state_q == WBCK) && !mem_req_o && !mem_ack_i;

    always_comb begin
        tag_we_o  = '0;
        data_we_o = '0;
        if (fill_write) begin
            tag_we_o[victim_q]  = 1'b1;
            data_we_o[victim_q] = 1'b1;
        end else if (store_hit) begin
            data_we_o[hit_way_i] = 1'b1;
        end
    end

    assign tag_wdata_o  = cpu_tag;
    assign data_wdata_o = fill_write ? mem_rdata_i : merged_word;

    assign touch_o     = (state_q == HIT);
    assign touch_way_o = (state_q == FILL) ? victim_q : hit_way_i;
    assign fill_o      = fill_write;
    assign set_dirty_o = store_hit;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q   <= IDLE;
            cpu_ack_o <= 1'b0;
            mem_req_o <= 1'b0;
            mem_we_o  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (cpu_req_i) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit_i) begin
                        state_q <= HIT;
                    end else if (victim_dirty_i) begin
                        state_q   <= WBCK;
                        mem_req_o <= 1'b1;
                        mem_we_o  <= 1'b1;
                    end else begin
                        state_q   <= FILL;
                        mem_req_o <= 1'b1;
                        mem_we_o  <= 1'b0;
                    end
                end
                WBCK: begin
                    if (mem_req_o && mem_ack_i) begin
                        mem_req_o <= 1'b0;
                    end else if (wbck_done) begin
                        state_q   <= FILL;
                        mem_req_o <= 1'b1;
                        mem_we_o  <= 1'b0;
                    end
                end
                FILL: begin
                    // wait for ack low so the arrays show the new line
                    if (mem_req_o && mem_ack_i) begin
                        mem_req_o <= 1'b0;
                    end else if (!mem_req_o && !mem_ack_i) begin
                        state_q <= HIT;
                    end
                end
                HIT: begin
                    state_q <= DONE;
                end
                DONE: begin
                    if (!cpu_ack_o) begin
                        cpu_ack_o <= 1'b1;
                    end else if (!cpu_req_i) begin
                        cpu_ack_o <= 1'b0;
                        state_q   <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == LOOKUP) begin
            victim_q    <= victim_way_i;
            mem_addr_o  <= victim_dirty_i ? wb_addr : fill_addr;
            mem_wdata_o <= victim_word;
        end
        if (wbck_done) begin
            mem_addr_o <= fill_addr;
        end
        if (state_q == HIT) begin
            cpu_rdata_o <= hit_word;
        end
    end

endmodule

// File: hdl/dcache_top.sv
// top level of the two-way write-back data cache
// tag and data arrays per way, metadata store and access controller
`include "dcache_defines.svh"

module dcache_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_req_i,
    input  logic              cpu_we_i,
    input  dcache_pkg::addr_t cpu_addr_i,
    input  dcache_pkg::data_t cpu_wdata_i,
    input  dcache_pkg::mask_t cpu_mask_i,
    output logic              cpu_ack_o,
    output dcache_pkg::data_t cpu_rdata_o,
    output logic              mem_req_o,
    output logic              mem_we_o,
    output dcache_pkg::addr_t mem_addr_o,
    output dcache_pkg::data_t mem_wdata_o,
    input  logic              mem_ack_i,
    input  dcache_pkg::data_t mem_rdata_i
);
    import dcache_pkg::*;

    index_t              index;
    tag_t                tag;
    tag_t                tag_rd [`DC_WAYS];
    data_t               data_rd [`DC_WAYS];
    logic [`DC_WAYS-1:0] tag_we;
    logic [`DC_WAYS-1:0] data_we;
    tag_t                tag_wdata;
    data_t               data_wdata;
    logic                hit;
    way_t                hit_way;
    way_t                victim_way;
    logic                victim_dirty;
    logic                touch;
    way_t                touch_way;
    logic                fill;
    logic                set_dirty;

    assign index = cpu_addr_i[`DC_INDEX_W+`DC_OFFSET_W-1:`DC_OFFSET_W];
    assign tag   = cpu_addr_i[`DC_ADDR_W-1:`DC_INDEX_W+`DC_OFFSET_W];

    dcache_array #(.entry_t(tag_t)) u_tag0 (
        .clk(clk), .we_i(tag_we[0]), .index_i(index),
        .wdata_i(tag_wdata), .rdata_o(tag_rd[0])
    );
    dcache_array #(.entry_t(tag_t)) u_tag1 (
        .clk(clk), .we_i(tag_we[1]), .index_i(index),
        .wdata_i(tag_wdata), .rdata_o(tag_rd[1])
    );
    dcache_array #(.entry_t(data_t)) u_data0 (
        .clk(clk), .we_i(data_we[0]), .index_i(index),
        .wdata_i(data_wdata), .rdata_o(data_rd[0])
    );
    dcache_array #(.entry_t(data_t)) u_data1 (
        .clk(clk), .we_i(data_we[1]), .index_i(index),
        .wdata_i(data_wdata), .rdata_o(data_rd[1])
    );

    dcache_meta u_meta (
        .clk(clk), .rst(rst), .index_i(index), .tag_i(tag),
        .tag0_i(tag_rd[0]), .tag1_i(tag_rd[1]),
        .touch_i(touch), .touch_way_i(touch_way),
        .fill_i(fill), .set_dirty_i(set_dirty),
        .hit_o(hit), .hit_way_o(hit_way),
        .victim_way_o(victim_way), .victim_dirty_o(victim_dirty)
    );

    dcache_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .cpu_req_i(cpu_req_i), .cpu_we_i(cpu_we_i), .cpu_addr_i(cpu_addr_i),
        .cpu_wdata_i(cpu_wdata_i), .cpu_mask_i(cpu_mask_i),
        .cpu_ack_o(cpu_ack_o), .cpu_rdata_o(cpu_rdata_o),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i),
        .tag_we_o(tag_we), .data_we_o(data_we),
        .tag_wdata_o(tag_wdata), .data_wdata_o(data_wdata),
        .data0_i(data_rd[0]), .data1_i(data_rd[1]),
        .tag0_i(tag_rd[0]), .tag1_i(tag_rd[1]),
        .hit_i(hit), .hit_way_i(hit_way),
        .victim_way_i(victim_way), .victim_dirty_i(victim_dirty),
        .touch_o(touch), .touch_way_o(touch_way),
        .fill_o(fill), .set_dirty_o(set_dirty)
    );

endmodule

// File: testbench/dcache_assert.sv
// handshake checks for the data cache
// memory request hold, CPU ack ordering and word-aligned memory addresses
module dcache_assert (
    input logic              clk,
    input logic              rst,
    input logic              cpu_req_i,
    input logic              cpu_ack_i,
    input logic              mem_req_i,
    input logic              mem_ack_i,
    input dcache_pkg::addr_t mem_addr_i
);

    int unsigned fail_cnt = 0;

    mem_req_held: assert property (@(posedge clk) disable iff (!rst)
        mem_req_i && !mem_ack_i |=> mem_req_i)
    else begin
        $error("mem_req_o dropped before mem_ack_i was seen");
        fail_cnt++;
    end

    // ack may only rise for a pending request
    cpu_ack_ordered: assert property (@(posedge clk) disable iff (!rst)
        !cpu_req_i |=> !$rose(cpu_ack_i))
    else begin
        $error("cpu_ack_o rose while cpu_req_i was low");
        fail_cnt++;
    end

    mem_addr_aligned: assert property (@(posedge clk) disable iff (!rst)
        mem_req_i |-> mem_addr_i[2:0] == 3'b000)
    else begin
        $error("mem_addr_o not word-aligned during a request");
        fail_cnt++;
    end

endmodule

bind dcache_top dcache_assert u_assert (
    .clk(clk), .rst(rst),
    .cpu_req_i(cpu_req_i), .cpu_ack_i(cpu_ack_o),
    .mem_req_i(mem_req_o), .mem_ack_i(mem_ack_i), .mem_addr_i(mem_addr_o)
);

// File: testbench/dcache_tb.sv
// data cache testbench
// replays the access sequence from the stimulus file against a memory
// model with random latency, checks load data, hit latency and writebacks
module dcache_tb;
    import dcache_pkg::*;

    localparam int    RESET_CYCLES    = 10;
    localparam int    CYCLES_PER_LINE = 40;
    localparam int    HIT_LATENCY     = 3;
    localparam data_t MEM_PATTERN     = 64'h5a5a_0000_a5a5_0000;
    localparam addr_t NO_WB           = 32'hffff_ffff;

    logic  clk;
    logic  rst;
    logic  cpu_req;
    logic  cpu_we;
    addr_t cpu_addr;
    data_t cpu_wdata;
    mask_t cpu_mask;
    logic  cpu_ack;
    data_t cpu_rdata;
    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    data_t mem_wdata;
    logic  mem_ack;
    data_t mem_rdata;

    integer seed        = 32'hb5c1;
    int     errors      = 0;
    int     tests       = 0;
    int     failed      = 0;
    int     cycle_cnt   = 0;
    int     cycle_limit = 0;
    int     rd_cnt      = 0;
    int     wr_cnt      = 0;

    data_t mem_model [addr_t];
    // architectural value of every stored word
    data_t shadow [addr_t];
    addr_t wb_addr_q [$];
    data_t wb_data_q [$];

    string t_name [$];
    logic  t_write [$];
    logic  t_hit [$];
    addr_t t_addr [$];
    data_t t_wdata [$];
    mask_t t_mask [$];
    data_t t_rdata [$];
    addr_t t_wb [$];

    dcache_top dut_i (
        .clk(clk), .rst(rst),
        .cpu_req_i(cpu_req), .cpu_we_i(cpu_we), .cpu_addr_i(cpu_addr),
        .cpu_wdata_i(cpu_wdata), .cpu_mask_i(cpu_mask),
        .cpu_ack_o(cpu_ack), .cpu_rdata_o(cpu_rdata),
        .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
        .mem_wdata_o(mem_wdata), .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // untouched memory returns its own address under a fixed pattern
    function automatic data_t init_word(input addr_t a);
        return {32'h0, a} ^ MEM_PATTERN;
    endfunction

    function automatic data_t current_word(input addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return init_word(a);
    endfunction

    function automatic data_t merge_store(input data_t old, input data_t wdata, input mask_t mask);
        data_t res;
        res = old;
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) begin
                res[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("Fail %s: data expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Fail %s: latency expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("Fail %s: address expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors != err_before) begin
            failed++;
        end
        $display("test %-12s %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    task automatic read_stim();
        int    fd;
        string line;
        string name;
        string op;
        string hm;
        addr_t addr;
        data_t wdata;
        mask_t mask;
        data_t rdata;
        addr_t wb;
        fd = $fopen("testbench/dcache_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file testbench/dcache_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                if ($sscanf(line, "%s %s %s %h %h %h %h %h",
                            name, op, hm, addr, wdata, mask, rdata, wb) == 8) begin
                    t_name.push_back(name);
                    t_write.push_back(op == "W");
                    t_hit.push_back(hm == "H");
                    t_addr.push_back(addr);
                    t_wdata.push_back(wdata);
                    t_mask.push_back(mask);
                    t_rdata.push_back(rdata);
                    t_wb.push_back(wb);
                end else begin
                    $display("malformed stimulus line: %s", line);
                    errors++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_reset();
        int err_before;
        err_before = errors;
        repeat (3) begin
            @(posedge clk);
            #1;
            if (cpu_ack !== 1'b0 || mem_req !== 1'b0) begin
                $display("reset: cpu_ack_o or mem_req_o not low with no request pending");
                errors++;
            end
        end
        report_test("reset", err_before);
    endtask

    task automatic run_access(input int i);
        int    err_before;
        int    cycles;
        data_t rdata;
        addr_t wa;
        err_before = errors;
        wa = t_addr[i] & ~addr_t'(7);
        rd_cnt = 0;
        wr_cnt = 0;
        wb_addr_q.delete();
        wb_data_q.delete();
        cpu_req   = 1'b1;
        cpu_we    = t_write[i];
        cpu_addr  = t_addr[i];
        cpu_wdata = t_wdata[i];
        cpu_mask  = t_mask[i];
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!cpu_ack);
        rdata   = cpu_rdata;
        cpu_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (cpu_ack);

        // the first edge only samples the request
        if (t_hit[i]) begin
            check_latency(t_name[i], HIT_LATENCY, cycles - 1);
            if (rd_cnt != 0 || wr_cnt != 0) begin
                $display("%s: memory was accessed on a hit", t_name[i]);
                errors++;
            end
        end else begin
            if (rd_cnt != 1) begin
                $display("Fail %s: line fills expected 1, actual %0d", t_name[i], rd_cnt);
                errors++;
            end
            if (t_wb[i] == NO_WB) begin
                if (wr_cnt != 0) begin
                    $display("%s: unexpected writeback to %h", t_name[i], wb_addr_q[0]);
                    errors++;
                end
            end else if (wr_cnt != 1) begin
                $display("Fail %s: writebacks expected 1, actual %0d", t_name[i], wr_cnt);
                errors++;
            end else begin
                check_addr(t_name[i], t_wb[i], wb_addr_q[0]);
                check_data(t_name[i], current_word(t_wb[i]), wb_data_q[0]);
            end
        end
        if (t_write[i]) begin
            shadow[wa] = merge_store(current_word(wa), t_wdata[i], t_mask[i]);
        end else begin
            check_data(t_name[i], t_rdata[i], rdata);
        end
        report_test(t_name[i], err_before);
    endtask

    // memory model answering each request after 1 to 4 cycles
    initial begin
        int lat;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req && !mem_ack) begin
                lat = 1 + ($unsigned($random(seed)) % 4);
                repeat (lat - 1) begin
                    @(posedge clk);
                    #1;
                end
                if (mem_we) begin
                    mem_model[mem_addr] = mem_wdata;
                    wb_addr_q.push_back(mem_addr);
                    wb_data_q.push_back(mem_wdata);
                    wr_cnt++;
                end else begin
                    mem_rdata = mem_model.exists(mem_addr) ? mem_model[mem_addr]
                                                           : init_word(mem_addr);
                    rd_cnt++;
                end
                mem_ack = 1'b1;
            end else if (!mem_req && mem_ack) begin
                mem_ack = 1'b0;
            end
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, an access never completed", cycle_cnt);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_mask  = '0;
        rst       = 1'b0;
        read_stim();
        if (t_name.size() == 0) begin
            $display("no stimulus lines were read");
            errors++;
        end
        cycle_limit = CYCLES_PER_LINE * t_name.size() + RESET_CYCLES + 10;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;
        check_reset();
        for (int i = 0; i < t_name.size(); i++) begin
            run_access(i);
        end
        if (dut_i.u_assert.fail_cnt != 0) begin
            $display("%0d handshake assertion failures", dut_i.u_assert.fail_cnt);
            errors += dut_i.u_assert.fail_cnt;
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests, tests - failed, failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/dcache_stim.txt
# name op(R/W) hit(H/M) addr wdata mask expected_rdata expected_writeback_addr
# rdata is ignored for stores, writeback addr ffffffff means none expected
rd_miss_a    R M 00001000 0000000000000000 00 5a5a0000a5a51000 ffffffff
rd_hit_a     R H 00001000 0000000000000000 00 5a5a0000a5a51000 ffffffff
wr_hit_a     W H 00001000 1122334455667788 0f 0000000000000000 ffffffff
rd_hit_a2    R H 00001000 0000000000000000 00 5a5a000055667788 ffffffff
rd_miss_b    R M 00001200 0000000000000000 00 5a5a0000a5a51200 ffffffff
rd_evict_a   R M 00001400 0000000000000000 00 5a5a0000a5a51400 00001000
rd_back_a    R M 00001000 0000000000000000 00 5a5a000055667788 ffffffff
rd_off_a     R H 00001006 0000000000000000 00 5a5a000055667788 ffffffff
wr_miss_d    W M 00002008 deadbeefcafef00d ff 0000000000000000 ffffffff
wr_miss_e    W M 00002208 0123456789abcdef f0 0000000000000000 ffffffff
rd_hit_d     R H 00002008 0000000000000000 00 deadbeefcafef00d ffffffff
rd_lru_f     R M 00002408 0000000000000000 00 5a5a0000a5a52408 00002208
rd_lru_e     R M 00002208 0000000000000000 00 01234567a5a52208 00002008
wr_hit_e     W H 00002208 ffeeddccbbaa9988 81 0000000000000000 ffffffff
rd_hit_e     R H 00002208 0000000000000000 00 ff234567a5a52288 ffffffff
rd_miss_d2   R M 00002008 0000000000000000 00 deadbeefcafef00d ffffffff
rd_miss_hi   R M fffffff8 0000000000000000 00 5a5a00005a5afff8 ffffffff
rd_hit_hi    R H fffffff8 0000000000000000 00 5a5a00005a5afff8 ffffffff

// File: filelist.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_array.sv
hdl/dcache_meta.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
testbench/dcache_assert.sv
testbench/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dcache_pkg.sv
      - hdl/dcache_array.sv
      - hdl/dcache_meta.sv
      - hdl/dcache_ctrl.sv
      - hdl/dcache_top.sv
  - target: test
    files:
      - testbench/dcache_assert.sv
      - testbench/dcache_tb.sv
